/* bench/quad_testdata.txt */
// Hex values: job count, then per job its row words and row count,
// followed by row words x row count pixel words of 128 bits each
3
1 2 // one-word rows
0123456789abcdeffedcba9876543210 8001c0de7f3e21a95566778899aabbcc
40 1 // one row that fills the buffer
5a003c00e1000f0096002700d8004b00 5a013c01e1010f0196012701d8014b01 5a023c02e1020f0296022702d8024b02
5a033c03e1030f0396032703d8034b03 5a043c04e1040f0496042704d8044b04 5a053c05e1050f0596052705d8054b05
5a063c06e1060f0696062706d8064b06 5a073c07e1070f0796072707d8074b07 5a083c08e1080f0896082708d8084b08
5a093c09e1090f0996092709d8094b09 5a0a3c0ae10a0f0a960a270ad80a4b0a 5a0b3c0be10b0f0b960b270bd80b4b0b
5a0c3c0ce10c0f0c960c270cd80c4b0c 5a0d3c0de10d0f0d960d270dd80d4b0d 5a0e3c0ee10e0f0e960e270ed80e4b0e
5a0f3c0fe10f0f0f960f270fd80f4b0f 5a103c10e1100f1096102710d8104b10 5a113c11e1110f1196112711d8114b11
5a123c12e1120f1296122712d8124b12 5a133c13e1130f1396132713d8134b13 5a143c14e1140f1496142714d8144b14
5a153c15e1150f1596152715d8154b15 5a163c16e1160f1696162716d8164b16 5a173c17e1170f1796172717d8174b17
5a183c18e1180f1896182718d8184b18 5a193c19e1190f1996192719d8194b19 5a1a3c1ae11a0f1a961a271ad81a4b1a
5a1b3c1be11b0f1b961b271bd81b4b1b 5a1c3c1ce11c0f1c961c271cd81c4b1c 5a1d3c1de11d0f1d961d271dd81d4b1d
5a1e3c1ee11e0f1e961e271ed81e4b1e 5a1f3c1fe11f0f1f961f271fd81f4b1f 5a203c20e1200f2096202720d8204b20
5a213c21e1210f2196212721d8214b21 5a223c22e1220f2296222722d8224b22 5a233c23e1230f2396232723d8234b23
5a243c24e1240f2496242724d8244b24 5a253c25e1250f2596252725d8254b25 5a263c26e1260f2696262726d8264b26
5a273c27e1270f2796272727d8274b27 5a283c28e1280f2896282728d8284b28 5a293c29e1290f2996292729d8294b29
5a2a3c2ae12a0f2a962a272ad82a4b2a 5a2b3c2be12b0f2b962b272bd82b4b2b 5a2c3c2ce12c0f2c962c272cd82c4b2c
5a2d3c2de12d0f2d962d272dd82d4b2d 5a2e3c2ee12e0f2e962e272ed82e4b2e 5a2f3c2fe12f0f2f962f272fd82f4b2f
5a303c30e1300f3096302730d8304b30 5a313c31e1310f3196312731d8314b31 5a323c32e1320f3296322732d8324b32
5a333c33e1330f3396332733d8334b33 5a343c34e1340f3496342734d8344b34 5a353c35e1350f3596352735d8354b35
5a363c36e1360f3696362736d8364b36 5a373c37e1370f3796372737d8374b37 5a383c38e1380f3896382738d8384b38
5a393c39e1390f3996392739d8394b39 5a3a3c3ae13a0f3a963a273ad83a4b3a 5a3b3c3be13b0f3b963b273bd83b4b3b
5a3c3c3ce13c0f3c963c273cd83c4b3c 5a3d3c3de13d0f3d963d273dd83d4b3d 5a3e3c3ee13e0f3e963e273ed83e4b3e
5a3f3c3fe13f0f3f963f273fd83f4b3f
3 2 // two rows of three words
7e21c4a9305bd86f12e4a7c0938b5f6d c3096b7e2a4f18d50e7b3c9621f4a8d3 3b8f5e1a6c07d924e9a2b4c7015f8e36
a4d7213f8e6c09b552e1f7a3c8064d9b 1f6e9c2b7a4d380f5c1b8e6a2d9470c3 86b2f40d1c93e7a5b07e3d2961c8f45a

/* bench/tb_quad.sv */
module tb_quad import quad_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int TDATA_WORDS = 128;
    localparam int MAX_JOBS = 8;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] LCG_SEED = 32'h2d4b_2026;

    logic        clk_if;
    logic        rst;
    logic        job_start;
    logic        job_accept;
    job_param_t  job_parameters;
    logic        job_fetch_request;
    logic        job_fetch_ack;
    logic        job_fetch_complete;
    logic        job_complete;
    logic        job_complete_ack;
    logic        pixel_valid;
    logic        pixel_ready;
    pixel_word_t pixel_data;
    logic        result_valid;
    logic        result_accept;
    pixel_word_t result_data;

    // File image and the jobs decoded from it
    pixel_word_t tdata [TDATA_WORDS];
    pixel_word_t expected_q [$];
    int          job_cols [MAX_JOBS];
    int          job_rows [MAX_JOBS];
    int          job_first [MAX_JOBS];
    int          job_end [MAX_JOBS];
    int          n_jobs;

    int          errors = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000;
    int          accepted_cnt;
    logic        window_open;
    logic        hold_pending;
    pixel_word_t held_data;
    logic [31:0] feed_seed = LCG_SEED;
    logic [31:0] accept_seed = LCG_SEED;

    cnn_layer_quad dut_i (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, want);
        end
    endtask

    ////////////////////
    // Clock and timeout
    ////////////////////

    initial begin
        clk_if = 1'b0;
        forever #10 clk_if = ~clk_if;
    end

    always @(posedge clk_if) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout at cycle %0d waiting for the DUT, %0d errors before it",
                     cycle_cnt, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////
    // Protocol monitor
    ////////////////////

    always @(posedge clk_if) begin
        if (rst) begin
            window_open  <= 1'b0;
            hold_pending <= 1'b0;
            accepted_cnt <= 0;
        end else begin
            if (pixel_ready) begin
                assert (pixel_valid && window_open) else begin
                    errors++;
                    $display("pixel_ready was high outside the fetch window or without valid");
                end
            end
            // Stalled result word must not move
            if (hold_pending) begin
                assert (result_valid) else begin
                    errors++;
                    $display("result_valid dropped before result_accept");
                end
                assert (result_data == held_data) else begin
                    errors++;
                    $display("ERROR result_data under back-pressure: got %h, expected %h",
                             result_data, held_data);
                end
            end
            hold_pending <= result_valid && !result_accept;
            held_data    <= result_data;
            if (result_valid && result_accept) begin
                accepted_cnt <= accepted_cnt + 1;
            end
            if (job_fetch_complete) begin
                window_open <= 1'b0;
            end else if (job_fetch_ack) begin
                window_open <= 1'b1;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic load_testdata();
        int idx;
        int words;
        $readmemh("bench/quad_testdata.txt", tdata);
        n_jobs = int'(tdata[0]);
        assert (n_jobs > 0 && n_jobs <= MAX_JOBS) else begin
            errors++;
            $display("Test data file missing or its job count %0d is out of range", n_jobs);
            n_jobs = 0;
        end
        idx = 1;
        for (int j = 0; j < n_jobs; j++) begin
            job_cols[j]  = int'(tdata[idx]);
            job_rows[j]  = int'(tdata[idx + 1]);
            job_first[j] = idx + 2;
            words = job_cols[j] * job_rows[j];
            for (int k = 0; k < words; k++) begin
                expected_q.push_back(tdata[idx + 2 + k]);
            end
            job_end[j] = expected_q.size();
            idx = idx + 2 + words;
        end
        cycle_limit = 8 * expected_q.size() + 200 * n_jobs + RESET_CYCLES + 10;
    endtask

    // Controller side of one row fetch with idle gaps on pixel_valid
    task automatic feed_row(input int first, input int count);
        int   sent;
        logic offered;
        sent = 0;
        offered = 1'b0;
        do begin
            @(posedge clk_if);
        end while (!job_fetch_request);
        job_fetch_ack <= 1'b1;
        @(posedge clk_if);
        job_fetch_ack <= 1'b0;
        while (sent < count) begin
            if (offered && pixel_ready) begin
                sent++;
                offered = 1'b0;
            end
            if (!offered && sent < count) begin
                feed_seed = lcg_step(feed_seed);
                if (feed_seed[31:30] != 2'b00) begin
                    offered = 1'b1;
                    pixel_data <= tdata[first + sent];
                end
            end
            pixel_valid <= offered;
            if (sent < count) begin
                @(posedge clk_if);
            end
        end
        job_fetch_complete <= 1'b1;
        @(posedge clk_if);
        job_fetch_complete <= 1'b0;
    endtask

    task automatic feed_pixels();
        for (int j = 0; j < n_jobs; j++) begin
            for (int r = 0; r < job_rows[j]; r++) begin
                feed_row(job_first[j] + r * job_cols[j], job_cols[j]);
            end
        end
    endtask

    task automatic drain_results();
        int idx;
        idx = 0;
        while (idx < expected_q.size()) begin
            @(posedge clk_if);
            if (result_valid && result_accept) begin
                assert (result_data == expected_q[idx]) else begin
                    errors++;
                    $display("ERROR result_data word %0d: got %h, expected %h",
                             idx, result_data, expected_q[idx]);
                end
                idx++;
            end
            accept_seed = lcg_step(accept_seed);
            result_accept <= (accept_seed[31:30] != 2'b00);
        end
        result_accept <= 1'b0;
    endtask

    task automatic run_job(input int j);
        job_param_t params;
        params = '0;
        params[COLS_LSB +: DIM_WIDTH] = dim_t'(job_cols[j]);
        params[ROWS_LSB +: DIM_WIDTH] = dim_t'(job_rows[j]);
        @(posedge clk_if);
        job_parameters <= params;
        job_start      <= 1'b1;
        // Start seen at the next edge and accept one cycle later
        @(posedge clk_if);
        check_bit("job_accept", job_accept, 1'b0);
        @(posedge clk_if);
        check_bit("job_accept", job_accept, 1'b1);
        job_start <= 1'b0;
        @(posedge clk_if);
        check_bit("job_accept", job_accept, 1'b0);
        do begin
            @(posedge clk_if);
        end while (!job_complete);
        assert (accepted_cnt == job_end[j]) else begin
            errors++;
            $display("ERROR accepted words at job_complete: got %h, expected %h",
                     accepted_cnt, job_end[j]);
        end
        // Completion held through a late ack
        repeat (3) begin
            @(posedge clk_if);
            check_bit("job_complete", job_complete, 1'b1);
        end
        job_complete_ack <= 1'b1;
        @(posedge clk_if);
        job_complete_ack <= 1'b0;
        @(posedge clk_if);
        check_bit("job_complete", job_complete, 1'b0);
    endtask

    task automatic control_jobs();
        for (int j = 0; j < n_jobs; j++) begin
            run_job(j);
        end
    endtask

    initial begin
        rst                <= 1'b1;
        job_start          <= 1'b0;
        job_parameters     <= '0;
        job_fetch_ack      <= 1'b0;
        job_fetch_complete <= 1'b0;
        job_complete_ack   <= 1'b0;
        pixel_valid        <= 1'b0;
        pixel_data         <= '0;
        result_accept      <= 1'b0;
        load_testdata();
        repeat (RESET_CYCLES) @(posedge clk_if);
        rst <= 1'b0;
        @(posedge clk_if);
        assert (!job_accept && !job_fetch_request && !job_complete && !result_valid
                && !pixel_ready) else begin
            errors++;
            $display("Handshake outputs were not all low after reset");
        end
        fork
            feed_pixels();
            drain_results();
            control_jobs();
        join
        repeat (4) begin
            @(posedge clk_if);
            check_bit("result_valid", result_valid, 1'b0);
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the quad testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_quad -f tb.f -Mdir obj_dir -o sim_tb_quad

./obj_dir/sim_tb_quad 2>&1 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation completed without failure"

/* src/cnn_layer_quad.sv */
module cnn_layer_quad import quad_pkg::*; (
    input  logic        clk_if,
    input  logic        rst,
    input  logic        job_start,
    output logic        job_accept,
    input  job_param_t  job_parameters,
    output logic        job_fetch_request,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    output logic        job_complete,
    input  logic        job_complete_ack,
    input  logic        pixel_valid,
    output logic        pixel_ready,
    input  pixel_word_t pixel_data,
    output logic        result_valid,
    input  logic        result_accept,
    output pixel_word_t result_data
);

    // Prefetch buffer write side
    logic        pfb_wr_en;
    pixel_word_t pfb_wr_data;
    logic        pfb_full;

    pfb_rd_if pfb_rd ();

    pixel_ingest i0_pixel_ingest (
        .clk_if             (clk_if),
        .rst                (rst),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .pixel_valid        (pixel_valid),
        .pixel_data         (pixel_data),
        .pixel_ready        (pixel_ready),
        .wr_en              (pfb_wr_en),
        .wr_data            (pfb_wr_data),
        .full               (pfb_full)
    );

    prefetch_fifo i0_prefetch_fifo (
        .clk_if  (clk_if),
        .rst     (rst),
        .wr_en   (pfb_wr_en),
        .wr_data (pfb_wr_data),
        .full    (pfb_full),
        .rd      (pfb_rd.buffer)
    );

    row_sequencer i0_row_sequencer (
        .clk_if            (clk_if),
        .rst               (rst),
        .job_start         (job_start),
        .job_parameters    (job_parameters),
        .job_accept        (job_accept),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .result_valid      (result_valid),
        .result_accept     (result_accept),
        .result_data       (result_data),
        .rd                (pfb_rd.sequencer)
    );

endmodule

/* src/pfb_rd_if.sv */
interface pfb_rd_if import quad_pkg::*; ();

    logic        rd_en;
    pixel_word_t rd_data;
    logic        empty;
    pfb_level_t  level;

    // FIFO side, head word shown without a read
    modport buffer (
        input  rd_en,
        output rd_data,
        output empty,
        output level
    );

    modport sequencer (
        output rd_en,
        input  rd_data,
        input  empty,
        input  level
    );

endinterface

/* src/pixel_ingest.sv */
module pixel_ingest import quad_pkg::*; (
    input  logic        clk_if,
    input  logic        rst,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    input  logic        pixel_valid,
    input  pixel_word_t pixel_data,
    output logic        pixel_ready,
    output logic        wr_en,
    output pixel_word_t wr_data,
    input  logic        full
);

    logic fetch_in_progress;

    ////////////////////
    // Fetch window
    ////////////////////

    // Complete wins over a simultaneous ack
    always_ff @(posedge clk_if) begin
        if (rst) begin
            fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            fetch_in_progress <= 1'b0;
        end else if (job_fetch_ack) begin
            fetch_in_progress <= 1'b1;
        end
    end

    ////////////////////
    // Pixel handshake and buffer write
    ////////////////////

    assign pixel_ready = pixel_valid && fetch_in_progress && !full;
    assign wr_en       = pixel_valid && pixel_ready;
    assign wr_data     = pixel_data;

    // Window opens one edge after the ack, so no word may be offered with the ack
    assert property (@(posedge clk_if) disable iff (rst)
        job_fetch_ack && !fetch_in_progress |-> !pixel_valid)
        else $error("pixel_valid raised while fetch ack still pending");

endmodule

/* src/prefetch_fifo.sv */
module prefetch_fifo import quad_pkg::*; (
    input  logic        clk_if,
    input  logic        rst,
    input  logic        wr_en,
    input  pixel_word_t wr_data,
    output logic        full,
    pfb_rd_if.buffer    rd
);

    pixel_word_t mem [PFB_DEPTH];

    pfb_addr_t  wr_ptr;
    pfb_addr_t  rd_ptr;
    pfb_level_t level;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk_if) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // First-word fall-through
    assign rd.rd_data = mem[rd_ptr];

    ////////////////////
    // Pointers and fill level
    ////////////////////

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk_if) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd.rd_en})
                2'b10: begin
                    level <= level + 1'b1;
                end
                2'b01: begin
                    level <= level - 1'b1;
                end
                default: begin
                    level <= level;
                end
            endcase
        end
    end

    ////////////////////
    // Status
    ////////////////////

    assign full     = (level == PFB_LEVEL_WIDTH'(PFB_DEPTH));
    assign rd.empty = (level == '0);
    assign rd.level = level;

    // Producer must respect full
    assert property (@(posedge clk_if) disable iff (rst)
        wr_en |-> !full)
        else $error("prefetch buffer overflow, level %0d", level);

    // Consumer must respect empty
    assert property (@(posedge clk_if) disable iff (rst)
        rd.rd_en |-> !rd.empty)
        else $error("prefetch buffer underflow");

endmodule

/* src/quad_pkg.sv */
package quad_pkg;

    ////////////////////
    // Pixel word geometry
    ////////////////////

    localparam int PIXEL_WIDTH = 16;

    // Four AWEs, two CEs each
    localparam int NUM_LANES = 8;

    localparam int WORD_WIDTH = PIXEL_WIDTH * NUM_LANES;

    ////////////////////
    // Prefetch buffer
    ////////////////////

    localparam int PFB_DEPTH = 64;
    localparam int PFB_ADDR_WIDTH = $clog2(PFB_DEPTH);

    // One extra bit so a full buffer is representable
    localparam int PFB_LEVEL_WIDTH = $clog2(PFB_DEPTH + 1);

    ////////////////////
    // Job parameters
    ////////////////////

    localparam int DIM_WIDTH = 9;
    localparam int JOB_PARAM_WIDTH = 128;

    // Field positions in job_parameters
    localparam int COLS_LSB = 0;
    localparam int ROWS_LSB = 9;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [WORD_WIDTH-1:0] pixel_word_t;

    typedef logic [PFB_LEVEL_WIDTH-1:0] pfb_level_t;

    typedef logic [PFB_ADDR_WIDTH-1:0] pfb_addr_t;

    // Row length in words or row count
    typedef logic [DIM_WIDTH-1:0] dim_t;

    typedef logic [JOB_PARAM_WIDTH-1:0] job_param_t;

    // Job sequencing states
    typedef enum logic [2:0] {
        st_idle,
        st_prim_buffer,
        st_wait_pfb_load,
        st_active,
        st_job_done
    } job_state_e;

endpackage

/* src/row_sequencer.sv */
module row_sequencer import quad_pkg::*; (
    input  logic        clk_if,
    input  logic        rst,
    input  logic        job_start,
    input  job_param_t  job_parameters,
    output logic        job_accept,
    output logic        job_fetch_request,
    input  logic        job_fetch_ack,
    output logic        job_complete,
    input  logic        job_complete_ack,
    output logic        result_valid,
    input  logic        result_accept,
    output pixel_word_t result_data,
    pfb_rd_if.sequencer rd
);

    job_state_e state;

    // Job dimensions, latched at accept
    dim_t row_words;
    dim_t num_rows;

    dim_t col_cnt;
    dim_t row_cnt;

    logic last_word;
    logic last_row;
    logic row_loaded;

    ////////////////////
    // Parameter capture
    ////////////////////

    always_ff @(posedge clk_if) begin
        if (state == st_idle && job_start) begin
            row_words <= job_parameters[COLS_LSB +: DIM_WIDTH];
            num_rows  <= job_parameters[ROWS_LSB +: DIM_WIDTH];
        end
    end

    assign last_word  = (col_cnt == row_words - 1'b1);
    assign last_row   = (row_cnt == num_rows - 1'b1);

    // Whole row present in the buffer
    assign row_loaded = (dim_t'(rd.level) >= row_words);

    ////////////////////
    // Job state machine
    ////////////////////

    always_ff @(posedge clk_if) begin
        if (rst) begin
            state      <= st_idle;
            job_accept <= 1'b0;
            col_cnt    <= '0;
            row_cnt    <= '0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                st_idle: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        row_cnt    <= '0;
                        state      <= st_prim_buffer;
                    end
                end
                st_prim_buffer: begin
                    // Request drops on the edge after the ack
                    if (job_fetch_ack) begin
                        state <= st_wait_pfb_load;
                    end
                end
                st_wait_pfb_load: begin
                    if (row_loaded) begin
                        col_cnt <= '0;
                        state   <= st_active;
                    end
                end
                st_active: begin
                    if (rd.rd_en) begin
                        if (last_word) begin
                            col_cnt <= '0;
                            if (last_row) begin
                                state <= st_job_done;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                                state   <= st_prim_buffer;
                            end
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                st_job_done: begin
                    if (job_complete_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign job_fetch_request = (state == st_prim_buffer);
    assign job_complete      = (state == st_job_done);

    // Head word held until accepted
    assign result_valid = (state == st_active) && !rd.empty;
    assign result_data  = rd.rd_data;
    assign rd.rd_en     = result_valid && result_accept;

    // A row must fit the buffer, else st_wait_pfb_load never exits
    assert property (@(posedge clk_if) disable iff (rst)
        state != st_idle |-> row_words != '0 && row_words <= DIM_WIDTH'(PFB_DEPTH))
        else $error("row length %0d outside 1..%0d", row_words, PFB_DEPTH);

    assert property (@(posedge clk_if) disable iff (rst)
        state inside {st_idle, st_prim_buffer, st_wait_pfb_load, st_active, st_job_done})
        else $error("job FSM in undefined state %0h", state);

endmodule

/* tb.f */
src/quad_pkg.sv
src/pfb_rd_if.sv
src/pixel_ingest.sv
src/prefetch_fifo.sv
src/row_sequencer.sv
src/cnn_layer_quad.sv
bench/tb_quad.sv
